// File: files.f
common/rvPkg.sv
fetch/fetchStage.sv
decode/instrDecoder.sv
decode/regFile.sv
decode/decodeStage.sv
verilog/executeStage.sv
verilog/memoryStage.sv
verilog/rvCore.sv
test/rvCoreTb.sv

// File: test/rvCoreTb.sv
`timescale 1ns/10ps

module rvCoreTb;
	import rvPkg::*;

	localparam int RAND_LEN = 80;
	localparam int PROG_LEN = RAND_LEN + 31;
	localparam int MAX_WAIT = 3;
	localparam int CYCLE_LIMIT = PROG_LEN * 5 + 50;
	localparam logic [11:0] DUMP_BASE = 12'h400;

	logic clk;
	logic reset;
	word_t instrAddr;
	instr_t instrData;
	logic wbCyc, wbStb, wbWe, wbAck;
	word_t wbAdr, wbDatOut;
	logic [XLEN/8-1:0] wbSel;

	instr_t rom [PROG_LEN];
	int delays [PROG_LEN];
	word_t expAdr [$];
	word_t expDat [$];
	regAddr_t recent [$];
	int expTotal;
	int storeCount = 0;
	int cycles = 0;
	int delayLeft;
	logic ackNext;
	logic waiting;
	word_t heldAdr, heldDat;

	rvCore i_dut (
		.clk(clk), .reset(reset), .instrAddr(instrAddr), .instrData(instrData),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatOut(wbDatOut), .wbSel(wbSel), .wbAck(wbAck)
	);

	// Instruction ROM returning NOPs past the end of the program
	assign instrData = (instrAddr[31:2] < PROG_LEN) ? rom[instrAddr[31:2]] : NOP_INSTR;

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic failRun(string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic checkWord(string name, word_t got, word_t exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
			failRun("Value mismatch on the data port");
		end
	endtask

	task automatic checkSel(string name, logic [XLEN/8-1:0] got, logic [XLEN/8-1:0] exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			failRun("Byte select mismatch on the data port");
		end
	endtask

	task automatic checkBit(string name, logic got, logic exp);
		if (got !== exp) begin
			$display("ERR %s: got 0x%0h, expected 0x%0h", name, got, exp);
			failRun("Control signal mismatch");
		end
	endtask

	// Sources lean toward the last three destinations
	function automatic regAddr_t pickSource();
		if ((recent.size() > 0) && ($urandom_range(9, 0) < 7))
			return recent[recent.size() - 1 - $urandom_range(recent.size() - 1, 0)];
		else
			return regAddr_t'($urandom_range(31, 0));
	endfunction

	task automatic buildProgram();
		int kind;
		logic [2:0] f3;
		logic [11:0] imm;
		regAddr_t rd, rs1, rs2;
		logic [6:0] f7;
		for (int i = 0; i < RAND_LEN; i++) begin
			kind = $urandom_range(9, 0);
			f3 = 3'($urandom_range(7, 0));
			rs1 = pickSource();
			rs2 = pickSource();
			rd = regAddr_t'($urandom_range(31, 0));
			imm = 12'($urandom);
			f7 = 7'd0;
			if ((f3 == F3_ADD_SUB || f3 == F3_SRL_SRA) && $urandom_range(1, 0))
				f7 = F7_ALT;
			if (kind < 4) begin
				rom[i] = {f7, rs2, rs1, f3, rd, OPC_OP};
			end else if (kind < 7) begin
				if (f3 == F3_SLL)
					imm[11:5] = 7'd0;
				else if (f3 == F3_SRL_SRA)
					imm[11:5] = f7;
				rom[i] = {imm, rs1, f3, rd, OPC_OP_IMM};
			end else if (kind < 8) begin
				rom[i] = {20'($urandom), rd, OPC_LUI};
			end else begin
				// Word store based on x0
				imm = {10'($urandom), 2'b00};
				rom[i] = {imm[11:5], rs2, 5'd0, F3_SW, imm[4:0], OPC_STORE};
			end
			if (kind < 8) begin
				recent.push_back(rd);
				if (recent.size() > 3)
					void'(recent.pop_front());
			end
		end
		// Register dump at the end
		for (int r = 1; r < 32; r++) begin
			imm = DUMP_BASE + 12'(r * 4);
			rom[RAND_LEN + r - 1] = {imm[11:5], 5'(r), 5'd0, F3_SW, imm[4:0], OPC_STORE};
		end
		for (int i = 0; i < PROG_LEN; i++)
			delays[i] = $urandom_range(MAX_WAIT, 0);
	endtask

	function automatic word_t aluRef(logic [2:0] f3, logic alt, word_t a, word_t b);
		case (f3)
			3'b000: return alt ? a - b : a + b;
			3'b001: return a << b[4:0];
			3'b010: return word_t'($signed(a) < $signed(b));
			3'b011: return word_t'(a < b);
			3'b100: return a ^ b;
			3'b101: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'b110: return a | b;
			default: return a & b;
		endcase
	endfunction

	// Architectural model that collects the stores in program order
	function automatic void runModel();
		word_t regs [32];
		instr_t ins;
		word_t b, res;
		logic alt;
		foreach (regs[r])
			regs[r] = '0;
		for (int i = 0; i < PROG_LEN; i++) begin
			ins = rom[i];
			if (ins[6:0] == OPC_STORE) begin
				expAdr.push_back(regs[ins[19:15]] + {{20{ins[31]}}, ins[31:25], ins[11:7]});
				expDat.push_back(regs[ins[24:20]]);
			end else begin
				b = (ins[6:0] == OPC_OP) ? regs[ins[24:20]] : {{20{ins[31]}}, ins[31:20]};
				alt = ins[30] && ((ins[6:0] == OPC_OP) || (ins[14:12] == 3'b101));
				res = aluRef(ins[14:12], alt, regs[ins[19:15]], b);
				if (ins[6:0] == OPC_LUI)
					res = {ins[31:12], 12'd0};
				if (ins[11:7] != 5'd0)
					regs[ins[11:7]] = res;
			end
		end
	endfunction

	task automatic recordTransfer();
		if (storeCount >= expTotal) begin
			failRun("Store seen after all expected stores had completed");
		end else begin
			checkBit("wbCyc", wbCyc, 1'b1);
			checkBit("wbWe", wbWe, 1'b1);
			checkWord("wbAdr", wbAdr, expAdr[storeCount]);
			checkWord("wbDatOut", wbDatOut, expDat[storeCount]);
			checkSel("wbSel", wbSel, '1);
			storeCount++;
		end
	endtask

	// Slave and checker work mid-cycle where the bus is settled
	always @(negedge clk) begin
		if (reset) begin
			ackNext = 1'b0;
			waiting = 1'b0;
			delayLeft = delays[0];
		end else begin
			if (waiting) begin
				checkBit("wbStb", wbStb, 1'b1);
				checkWord("wbAdr", wbAdr, heldAdr);
				checkWord("wbDatOut", wbDatOut, heldDat);
			end
			if (wbStb && wbAck) begin
				recordTransfer();
				ackNext = 1'b0;
				waiting = 1'b0;
				delayLeft = (storeCount < PROG_LEN) ? delays[storeCount] : 0;
			end else if (wbStb) begin
				waiting = 1'b1;
				heldAdr = wbAdr;
				heldDat = wbDatOut;
				if (delayLeft == 0)
					ackNext = 1'b1;
				else
					delayLeft--;
			end
		end
	end

	always @(posedge clk) begin
		wbAck <= reset ? 1'b0 : ackNext;
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
			failRun($sformatf("Timeout after %0d cycles, %0d of %0d stores never completed",
				cycles, expTotal - storeCount, expTotal));
	end

	initial begin
		void'($urandom(32'ha3899e40));
		reset = 1'b1;
		wbAck = 1'b0;
		ackNext = 1'b0;
		waiting = 1'b0;
		buildProgram();
		runModel();
		expTotal = expAdr.size();
		repeat (2) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		checkWord("instrAddr", instrAddr, RESET_PC);
		checkBit("wbCyc", wbCyc, 1'b0);
		checkBit("wbStb", wbStb, 1'b0);
		wait (storeCount == expTotal);
		// Give a duplicate store time to show up
		repeat (10) @(posedge clk);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

// File: verilog/rvCore.sv
`timescale 1ns/10ps

module rvCore (
	input logic clk,
	input logic reset,
	output rvPkg::word_t instrAddr,
	input rvPkg::instr_t instrData,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output rvPkg::word_t wbAdr,
	output rvPkg::word_t wbDatOut,
	output logic [rvPkg::XLEN/8-1:0] wbSel,
	input logic wbAck
);
	import rvPkg::*;

	logic hold;
	instr_t instr;
	logic idValid, idWriteReg, idIsStore;
	word_t operandA, operandB, storeData;
	regAddr_t idRd;
	aluOp_t idAluOp;
	regAddr_t exRd, memRd, wbRd;
	logic exWriteReg, memWriteReg, exValid, exIsStore, wbValid;
	word_t exResult, memResult, exStoreData, wbData;

	fetchStage i_fetchStage (
		.clk(clk), .reset(reset), .hold(hold), .instrData(instrData),
		.instrAddr(instrAddr), .instr(instr), .pc()
	);

	decodeStage i_decodeStage (
		.clk(clk), .reset(reset), .hold(hold), .instr(instr),
		.wbValid(wbValid), .wbRd(wbRd), .wbData(wbData),
		.exRd(exRd), .exWriteReg(exWriteReg), .exResult(exResult),
		.memRd(memRd), .memWriteReg(memWriteReg), .memResult(memResult),
		.idValid(idValid), .operandA(operandA), .operandB(operandB), .storeData(storeData),
		.idRd(idRd), .idAluOp(idAluOp), .idWriteReg(idWriteReg), .idIsStore(idIsStore)
	);

	executeStage i_executeStage (
		.clk(clk), .reset(reset), .hold(hold), .idValid(idValid),
		.operandA(operandA), .operandB(operandB), .storeData(storeData),
		.idRd(idRd), .idAluOp(idAluOp), .idWriteReg(idWriteReg), .idIsStore(idIsStore),
		.exRd(exRd), .exWriteReg(exWriteReg), .exResult(exResult),
		.exValid(exValid), .exStoreData(exStoreData), .exIsStore(exIsStore),
		.memRd(memRd), .memWriteReg(memWriteReg), .memResult(memResult)
	);

	// Execute/memory register contents also serve as memory-stage forwarding
	memoryStage i_memoryStage (
		.clk(clk), .reset(reset), .exValid(exValid), .exIsStore(exIsStore),
		.exResult(memResult), .exStoreData(exStoreData),
		.memRd(memRd), .memWriteReg(memWriteReg), .hold(hold),
		.wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe), .wbAdr(wbAdr),
		.wbDatOut(wbDatOut), .wbSel(wbSel), .wbAck(wbAck),
		.wbValid(wbValid), .wbRd(wbRd), .wbData(wbData)
	);

endmodule

// File: verilog/memoryStage.sv
`timescale 1ns/10ps

module memoryStage (
	input logic clk,
	input logic reset,
	input logic exValid,
	input logic exIsStore,
	input rvPkg::word_t exResult,
	input rvPkg::word_t exStoreData,
	input rvPkg::regAddr_t memRd,
	input logic memWriteReg,
	output logic hold,
	output logic wbCyc,
	output logic wbStb,
	output logic wbWe,
	output rvPkg::word_t wbAdr,
	output rvPkg::word_t wbDatOut,
	output logic [rvPkg::XLEN/8-1:0] wbSel,
	input logic wbAck,
	output logic wbValid,
	output rvPkg::regAddr_t wbRd,
	output rvPkg::word_t wbData
);
	import rvPkg::*;

	logic storeActive;

	assign storeActive = exValid && exIsStore;

	// Front of the pipeline waits until the slave acks
	assign hold = storeActive && !wbAck;

	assign wbCyc = storeActive;
	assign wbStb = storeActive;
	assign wbWe = storeActive;
	assign wbAdr = exResult;
	assign wbDatOut = exStoreData;
	assign wbSel = '1;

	always_ff @(posedge clk) begin
		if (reset)
			wbValid <= 1'b0;
		else
			wbValid <= memWriteReg && !hold;
	end

	always_ff @(posedge clk) begin
		wbRd <= memRd;
		wbData <= exResult;
	end

	stbInCyc: assert property (@(posedge clk) disable iff (reset)
		wbStb |-> wbCyc);

	stableWhileWaiting: assert property (@(posedge clk) disable iff (reset)
		(wbStb && !wbAck) |=> wbStb && $stable(wbAdr) && $stable(wbDatOut));

endmodule

// File: verilog/executeStage.sv
`timescale 1ns/10ps

module executeStage (
	input logic clk,
	input logic reset,
	input logic hold,
	input logic idValid,
	input rvPkg::word_t operandA,
	input rvPkg::word_t operandB,
	input rvPkg::word_t storeData,
	input rvPkg::regAddr_t idRd,
	input rvPkg::aluOp_t idAluOp,
	input logic idWriteReg,
	input logic idIsStore,
	output rvPkg::regAddr_t exRd,
	output logic exWriteReg,
	output rvPkg::word_t exResult,
	output logic exValid,
	output rvPkg::word_t exStoreData,
	output logic exIsStore,
	output rvPkg::regAddr_t memRd,
	output logic memWriteReg,
	output rvPkg::word_t memResult
);
	import rvPkg::*;

	logic [4:0] shamt;

	assign shamt = operandB[4:0];

	always_comb begin
		case (idAluOp)
			ALU_ADD: exResult = operandA + operandB;
			ALU_SUB: exResult = operandA - operandB;
			ALU_AND: exResult = operandA & operandB;
			ALU_OR: exResult = operandA | operandB;
			ALU_XOR: exResult = operandA ^ operandB;
			ALU_SLL: exResult = operandA << shamt;
			ALU_SRL: exResult = operandA >> shamt;
			ALU_SRA: exResult = word_t'($signed(operandA) >>> shamt);
			ALU_SLT: exResult = word_t'($signed(operandA) < $signed(operandB));
			ALU_SLTU: exResult = word_t'(operandA < operandB);
			default: exResult = operandB;
		endcase
	end

	// Forwarding from the instruction now in execute
	assign exRd = idRd;
	assign exWriteReg = idValid && idWriteReg;

	always_ff @(posedge clk) begin
		if (reset) begin
			exValid <= 1'b0;
			exIsStore <= 1'b0;
			memWriteReg <= 1'b0;
		end else if (!hold) begin
			exValid <= idValid;
			exIsStore <= idIsStore;
			memWriteReg <= exWriteReg;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			memRd <= idRd;
			memResult <= exResult;
			exStoreData <= storeData;
		end
	end

	knownAluOp: assert property (@(posedge clk) disable iff (reset)
		idValid |-> (idAluOp <= ALU_PASSB));

endmodule

// File: decode/decodeStage.sv
`timescale 1ns/10ps

module decodeStage (
	input logic clk,
	input logic reset,
	input logic hold,
	input rvPkg::instr_t instr,
	input logic wbValid,
	input rvPkg::regAddr_t wbRd,
	input rvPkg::word_t wbData,
	input rvPkg::regAddr_t exRd,
	input logic exWriteReg,
	input rvPkg::word_t exResult,
	input rvPkg::regAddr_t memRd,
	input logic memWriteReg,
	input rvPkg::word_t memResult,
	output logic idValid,
	output rvPkg::word_t operandA,
	output rvPkg::word_t operandB,
	output rvPkg::word_t storeData,
	output rvPkg::regAddr_t idRd,
	output rvPkg::aluOp_t idAluOp,
	output logic idWriteReg,
	output logic idIsStore
);
	import rvPkg::*;

	regAddr_t rs1, rs2, rd;
	word_t imm, rdata1, rdata2, fwdA, fwdB;
	aluOp_t aluOp;
	logic useImm, writeReg, isStore, legal;

	// Youngest producer wins; x0 reads zero from the register file
	function automatic word_t pickOperand(regAddr_t src, word_t regVal);
		if (src == '0)
			return regVal;
		else if (exWriteReg && (exRd == src))
			return exResult;
		else if (memWriteReg && (memRd == src))
			return memResult;
		else
			return regVal;
	endfunction

	instrDecoder i_instrDecoder (
		.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm), .useImm(useImm),
		.aluOp(aluOp), .writeReg(writeReg), .isStore(isStore), .legal(legal)
	);

	regFile i_regFile (
		.clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rdata1(rdata1), .rdata2(rdata2),
		.wrEn(wbValid), .wrAddr(wbRd), .wrData(wbData)
	);

	always_comb begin
		fwdA = pickOperand(rs1, rdata1);
		fwdB = pickOperand(rs2, rdata2);
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			idValid <= 1'b0;
			idWriteReg <= 1'b0;
			idIsStore <= 1'b0;
		end else if (!hold) begin
			idValid <= legal;
			idWriteReg <= writeReg;
			idIsStore <= isStore;
		end
	end

	always_ff @(posedge clk) begin
		if (!hold) begin
			operandA <= fwdA;
			operandB <= useImm ? imm : fwdB;
			storeData <= fwdB;
			idRd <= rd;
			idAluOp <= aluOp;
		end
	end

endmodule

// File: decode/regFile.sv
`timescale 1ns/10ps

module regFile (
	input logic clk,
	input logic reset,
	input rvPkg::regAddr_t rs1,
	input rvPkg::regAddr_t rs2,
	output rvPkg::word_t rdata1,
	output rvPkg::word_t rdata2,
	input logic wrEn,
	input rvPkg::regAddr_t wrAddr,
	input rvPkg::word_t wrData
);
	import rvPkg::*;

	word_t regs [1:31];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wrEn && (wrAddr != '0)) begin
			regs[wrAddr] <= wrData;
		end
	end

	// Write-through covers the instruction three ahead
	assign rdata1 = (rs1 == '0) ? '0 : (wrEn && (wrAddr == rs1)) ? wrData : regs[rs1];
	assign rdata2 = (rs2 == '0) ? '0 : (wrEn && (wrAddr == rs2)) ? wrData : regs[rs2];

	zeroReg: assert property (@(posedge clk) disable iff (reset)
		(rs1 == '0) |-> (rdata1 == '0));

endmodule

// File: decode/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder (
	input rvPkg::instr_t instr,
	output rvPkg::regAddr_t rs1,
	output rvPkg::regAddr_t rs2,
	output rvPkg::regAddr_t rd,
	output rvPkg::word_t imm,
	output logic useImm,
	output rvPkg::aluOp_t aluOp,
	output logic writeReg,
	output logic isStore,
	output logic legal
);
	import rvPkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic shiftOp;

	function automatic aluOp_t aluFor(logic [2:0] f3, logic alt);
		case (f3)
			F3_ADD_SUB: return alt ? ALU_SUB : ALU_ADD;
			F3_SLL: return ALU_SLL;
			F3_SLT: return ALU_SLT;
			F3_SLTU: return ALU_SLTU;
			F3_XOR: return ALU_XOR;
			F3_SRL_SRA: return alt ? ALU_SRA : ALU_SRL;
			F3_OR: return ALU_OR;
			default: return ALU_AND;
		endcase
	endfunction

	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];
	assign rs1 = instr[19:15];
	assign rs2 = instr[24:20];
	assign rd = instr[11:7];
	assign shiftOp = (funct3 == F3_SLL) || (funct3 == F3_SRL_SRA);

	always_comb begin
		imm = '0;
		useImm = 1'b0;
		aluOp = ALU_ADD;
		writeReg = 1'b0;
		isStore = 1'b0;
		legal = 1'b0;
		case (opcode)
			OPC_OP: begin
				aluOp = aluFor(funct3, funct7 == F7_ALT);
				writeReg = 1'b1;
				// Alternate encoding only exists for sub and sra
				legal = (funct7 == 7'd0) || ((funct7 == F7_ALT) &&
					((funct3 == F3_ADD_SUB) || (funct3 == F3_SRL_SRA)));
			end
			OPC_OP_IMM: begin
				aluOp = aluFor(funct3, (funct3 == F3_SRL_SRA) && (funct7 == F7_ALT));
				imm = {{20{instr[31]}}, instr[31:20]};
				useImm = 1'b1;
				writeReg = 1'b1;
				legal = !shiftOp || (funct7 == 7'd0) ||
					((funct3 == F3_SRL_SRA) && (funct7 == F7_ALT));
			end
			OPC_LUI: begin
				aluOp = ALU_PASSB;
				imm = {instr[31:12], 12'd0};
				useImm = 1'b1;
				writeReg = 1'b1;
				legal = 1'b1;
			end
			OPC_STORE: begin
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				useImm = 1'b1;
				isStore = 1'b1;
				legal = (funct3 == F3_SW);
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin
			writeReg = 1'b0;
			isStore = 1'b0;
		end
	end

endmodule

// File: fetch/fetchStage.sv
`timescale 1ns/10ps

module fetchStage (
	input logic clk,
	input logic reset,
	input logic hold,
	input rvPkg::instr_t instrData,
	output rvPkg::word_t instrAddr,
	output rvPkg::instr_t instr,
	output rvPkg::word_t pc
);
	import rvPkg::*;

	always_ff @(posedge clk) begin
		if (reset) begin
			instrAddr <= RESET_PC;
			instr <= NOP_INSTR;
		end else if (!hold) begin
			instrAddr <= instrAddr + word_t'(4);
			instr <= instrData;
		end
	end

	// PC of the word now in the fetch/decode register
	always_ff @(posedge clk) begin
		if (!hold)
			pc <= instrAddr;
	end

	pcHeld: assert property (@(posedge clk) disable iff (reset)
		hold |=> (instrAddr == $past(instrAddr)) && (pc == $past(pc)));

endmodule

// File: common/rvPkg.sv
package rvPkg;

	localparam int XLEN = 32;
	localparam int REG_ADDR_W = 5;

	typedef logic [XLEN-1:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [REG_ADDR_W-1:0] regAddr_t;
	typedef logic [3:0] aluOp_t;

	// Major opcodes of the supported subset
	localparam logic [6:0] OPC_OP = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_LUI = 7'b0110111;
	localparam logic [6:0] OPC_STORE = 7'b0100011;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL = 3'b001;
	localparam logic [2:0] F3_SLT = 3'b010;
	localparam logic [2:0] F3_SLTU = 3'b011;
	localparam logic [2:0] F3_XOR = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR = 3'b110;
	localparam logic [2:0] F3_AND = 3'b111;
	localparam logic [2:0] F3_SW = 3'b010;

	// Marks sub and sra
	localparam logic [6:0] F7_ALT = 7'b0100000;

	localparam aluOp_t ALU_ADD = 4'd0;
	localparam aluOp_t ALU_SUB = 4'd1;
	localparam aluOp_t ALU_AND = 4'd2;
	localparam aluOp_t ALU_OR = 4'd3;
	localparam aluOp_t ALU_XOR = 4'd4;
	localparam aluOp_t ALU_SLL = 4'd5;
	localparam aluOp_t ALU_SRL = 4'd6;
	localparam aluOp_t ALU_SRA = 4'd7;
	localparam aluOp_t ALU_SLT = 4'd8;
	localparam aluOp_t ALU_SLTU = 4'd9;
	// Highest defined code, used by lui
	localparam aluOp_t ALU_PASSB = 4'd10;

	// addi x0, x0, 0
	localparam instr_t NOP_INSTR = 32'h0000_0013;
	localparam word_t RESET_PC = '0;

endpackage
